/* logic/imm_settings.svh */
`ifndef IMM_SETTINGS_SVH
`define IMM_SETTINGS_SVH

// Data word width.
`define IMM_XLEN 32

// Serial cycles per instruction, one immediate bit each.
`define IMM_CNT_LEN 32

// 1 lets the register addresses share the immediate shift registers.
`define IMM_SHARED_REGS 1

`endif

/* logic/imm_pkg.sv */
`include "imm_settings.svh"

package imm_pkg;

   // Immediate format class, decoded from opcode and funct3.
   typedef enum logic [2:0] {
      FMT_I,
      FMT_S,
      FMT_U,
      FMT_CSR,
      FMT_NONE
   } imm_fmt_e;

   typedef enum logic [1:0] {
      IDLE,
      COUNT,
      DONE
   } seq_state_e;

   // Decoder control word, driven by the sequencer every cycle.
   typedef struct packed {
      logic       load;       // Capture instruction fields.
      logic       cnt_en;     // Serial count cycle.
      logic       cnt_done;   // Last count cycle.
      logic [3:0] shift_en;   // 3 imm30_25, 2 imm24_20, 1 imm19_12_20, 0 imm11_7.
      logic [3:0] sel;        // 3 hi fill sign, 2 mid fill sign, 1 zero out, 0 rd out.
      logic       csr_imm;    // Zero-extended CSR immediate.
   } immdec_ctrl_t;

   typedef struct packed {
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
   } reg_addr_t;

   typedef struct packed {
      logic [`IMM_XLEN-1:0] value;
      imm_fmt_e             fmt;
   } imm_result_t;

endpackage

/* logic/imm_sequencer.sv */
`timescale 1ns/1ns
`include "imm_settings.svh"

module imm_sequencer (
   input  logic                    i_clk,
   input  logic                    i_rst,
   input  logic                    i_valid,
   input  logic [`IMM_XLEN-1:0]    i_instr,
   output imm_pkg::immdec_ctrl_t   o_ctrl,
   output logic [`IMM_XLEN-1:7]    o_wb_rdt,
   output imm_pkg::imm_fmt_e       o_fmt,
   output logic                    o_csr_sel,
   output logic                    o_finish,
   output logic                    o_busy
);

   localparam int CNT_W = $clog2(`IMM_CNT_LEN);
   localparam int U_LOW = 12;   // Zero bits below a U-type immediate.

   typedef enum logic [4:0] {
      OP_LOAD   = 5'b00000,
      OP_IMM    = 5'b00100,
      OP_AUIPC  = 5'b00101,
      OP_STORE  = 5'b01000,
      OP_LUI    = 5'b01101,
      OP_BRANCH = 5'b11000,
      OP_JALR   = 5'b11001,
      OP_JAL    = 5'b11011,
      OP_SYSTEM = 5'b11100
   } opcode_e;

   imm_pkg::seq_state_e state;
   imm_pkg::imm_fmt_e   fmt_in;
   imm_pkg::imm_fmt_e   fmt_q;
   opcode_e             opcode;
   logic [CNT_W-1:0]    cnt;
   logic                accept;
   logic                cnt_done;

   assign opcode   = opcode_e'(i_instr[6:2]);
   assign accept   = i_valid && (state == imm_pkg::IDLE);
   assign cnt_done = (state == imm_pkg::COUNT) && (cnt == CNT_W'(`IMM_CNT_LEN - 1));

   always_comb begin
      case (opcode)
         OP_LOAD, OP_IMM, OP_JALR: fmt_in = imm_pkg::FMT_I;
         OP_STORE:                 fmt_in = imm_pkg::FMT_S;
         OP_LUI, OP_AUIPC:         fmt_in = imm_pkg::FMT_U;
         OP_SYSTEM:                fmt_in = i_instr[14] ? imm_pkg::FMT_CSR : imm_pkg::FMT_I;
         OP_BRANCH, OP_JAL:        fmt_in = imm_pkg::FMT_NONE;
         default:                  fmt_in = imm_pkg::FMT_NONE;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state <= imm_pkg::IDLE;
         cnt   <= '0;
         fmt_q <= imm_pkg::FMT_NONE;
      end else begin
         case (state)
            imm_pkg::IDLE: begin
               if (i_valid) begin
                  state <= imm_pkg::COUNT;
                  cnt   <= '0;
                  fmt_q <= fmt_in;
               end
            end
            imm_pkg::COUNT: begin
               cnt <= cnt + 1'b1;   // Wraps to zero after the last bit.
               if (cnt_done) begin
                  state <= imm_pkg::DONE;
               end
            end
            default: state <= imm_pkg::IDLE;
         endcase
      end
   end

   // Shift chains per format. I and S run imm30_25 into the output register with
   // sign fill. U rotates the whole ring for the twelve zero cycles, which brings
   // bit 12 to the output just as the zero window ends.
   always_comb begin
      o_ctrl          = '0;
      o_ctrl.load     = accept && (fmt_in != imm_pkg::FMT_NONE);
      o_ctrl.cnt_en   = (state == imm_pkg::COUNT);
      o_ctrl.cnt_done = cnt_done;
      o_ctrl.csr_imm  = accept ? (fmt_in == imm_pkg::FMT_CSR) : (fmt_q == imm_pkg::FMT_CSR);
      if (state == imm_pkg::COUNT) begin
         case (fmt_q)
            imm_pkg::FMT_I: begin
               o_ctrl.shift_en = 4'b1100;
               o_ctrl.sel      = 4'b0100;
            end
            imm_pkg::FMT_S: begin
               o_ctrl.shift_en = 4'b1001;
               o_ctrl.sel      = 4'b0101;
            end
            imm_pkg::FMT_U: begin
               o_ctrl.shift_en = 4'b1110;
               o_ctrl.sel      = {2'b00, cnt < CNT_W'(U_LOW), 1'b0};
            end
            imm_pkg::FMT_CSR: begin
               o_ctrl.shift_en = 4'b0010;   // Sign is clear, so zeros follow.
               o_ctrl.sel      = 4'b1000;
            end
            default: begin
               o_ctrl.shift_en = 4'b0000;
               o_ctrl.sel      = 4'b0000;
            end
         endcase
      end
   end

   assign o_wb_rdt  = i_instr[`IMM_XLEN-1:7];
   assign o_fmt     = fmt_q;
   assign o_csr_sel = (fmt_q == imm_pkg::FMT_CSR);
   assign o_finish  = cnt_done && (fmt_q != imm_pkg::FMT_NONE);
   assign o_busy    = (state != imm_pkg::IDLE);

   a_done_after_accept: assert property (@(posedge i_clk) disable iff (i_rst)
      cnt_done |-> $past(accept, `IMM_CNT_LEN));

endmodule

/* logic/serial_immdec.sv */
`timescale 1ns/1ns

module serial_immdec #(
   parameter int SHARED_RFADDR_IMM_REGS = 1
) (
   input  logic                  i_clk,
   input  imm_pkg::immdec_ctrl_t i_ctrl,
   input  logic [31:7]           i_wb_rdt,
   output imm_pkg::reg_addr_t    o_addr,
   output logic                  o_imm,
   output logic                  o_csr_imm
);

   logic       signbit;
   logic [8:0] imm19_12_20;   // Bits 19:12, then bit 20 at the bottom.
   logic [5:0] imm30_25;
   logic [4:0] imm24_20;
   logic [4:0] imm11_7;
   logic       fill_hi;
   logic       fill_mid;

   assign fill_hi  = i_ctrl.sel[3] ? signbit : imm24_20[0];
   assign fill_mid = i_ctrl.sel[2] ? signbit : imm19_12_20[0];

   always_ff @(posedge i_clk) begin
      if (i_ctrl.load) begin
         signbit     <= i_wb_rdt[31] & ~i_ctrl.csr_imm;   // CSR immediates never sign-extend.
         imm19_12_20 <= {i_wb_rdt[19:12], i_wb_rdt[20]};
         imm30_25    <= i_wb_rdt[30:25];
         imm24_20    <= i_wb_rdt[24:20];
         imm11_7     <= i_wb_rdt[11:7];
      end else if (i_ctrl.cnt_en) begin
         if (i_ctrl.shift_en[1]) begin
            imm19_12_20 <= {fill_hi, imm19_12_20[8:1]};
         end
         if (i_ctrl.shift_en[3]) begin
            imm30_25 <= {fill_mid, imm30_25[5:1]};
         end
         if (i_ctrl.shift_en[2]) begin
            imm24_20 <= {imm30_25[0], imm24_20[4:1]};
         end
         if (i_ctrl.shift_en[0]) begin
            imm11_7 <= {imm30_25[0], imm11_7[4:1]};
         end
      end
   end

   generate
      if (SHARED_RFADDR_IMM_REGS != 0) begin : g_shared
         // Valid only until the first shift.
         assign o_addr = '{
            rd:  imm11_7,
            rs1: imm19_12_20[8:4],
            rs2: imm24_20
         };
      end else begin : g_split
         imm_pkg::reg_addr_t addr_q;

         always_ff @(posedge i_clk) begin
            if (i_ctrl.load) begin
               addr_q <= '{
                  rd:  i_wb_rdt[11:7],
                  rs1: i_wb_rdt[19:15],
                  rs2: i_wb_rdt[24:20]
               };
            end
         end

         assign o_addr = addr_q;
      end
   endgenerate

   assign o_csr_imm = imm19_12_20[4];
   assign o_imm     = i_ctrl.cnt_done ? signbit :
                      i_ctrl.sel[1]   ? 1'b0 :
                      i_ctrl.sel[0]   ? imm11_7[0] : imm24_20[0];

   a_done_in_count: assert property (@(posedge i_clk)
      i_ctrl.cnt_done |-> i_ctrl.cnt_en);

endmodule

/* logic/imm_collector.sv */
`timescale 1ns/1ns
`include "imm_settings.svh"

module imm_collector (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_shift,
   input  logic                 i_csr_sel,
   input  logic                 i_imm,
   input  logic                 i_csr_imm,
   input  imm_pkg::imm_fmt_e    i_fmt,
   input  logic                 i_finish,
   output imm_pkg::imm_result_t o_result,
   output logic                 o_valid
);

   logic [`IMM_XLEN-1:0] shreg;
   logic                 bit_in;

   // The CSR stream runs to zero on its own after its five bits.
   assign bit_in = i_csr_sel ? i_csr_imm : i_imm;

   always_ff @(posedge i_clk) begin
      if (i_shift) begin
         shreg <= {bit_in, shreg[`IMM_XLEN-1:1]};   // LSB first.
      end
      if (i_finish) begin
         o_result.value <= {bit_in, shreg[`IMM_XLEN-1:1]};   // Includes the final bit.
         o_result.fmt   <= i_fmt;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_valid <= 1'b0;
      end else begin
         o_valid <= i_finish;
      end
   end

   a_single_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
      o_valid |=> !o_valid);

endmodule

/* logic/serial_imm_unit.sv */
`timescale 1ns/1ns
`include "imm_settings.svh"

module serial_imm_unit (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_valid,
   input  logic [`IMM_XLEN-1:0] i_instr,
   output logic                 o_busy,
   output imm_pkg::reg_addr_t   o_addr,
   output imm_pkg::imm_result_t o_result,
   output logic                 o_result_valid
);

   imm_pkg::immdec_ctrl_t ctrl;
   imm_pkg::imm_fmt_e     fmt;
   logic [`IMM_XLEN-1:7]  wb_rdt;
   logic                  csr_sel;
   logic                  finish;
   logic                  imm;
   logic                  csr_imm;

   imm_sequencer u_sequencer (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_valid   (i_valid),
      .i_instr   (i_instr),
      .o_ctrl    (ctrl),
      .o_wb_rdt  (wb_rdt),
      .o_fmt     (fmt),
      .o_csr_sel (csr_sel),
      .o_finish  (finish),
      .o_busy    (o_busy)
   );

   serial_immdec #(
      .SHARED_RFADDR_IMM_REGS (`IMM_SHARED_REGS)
   ) u_immdec (
      .i_clk     (i_clk),
      .i_ctrl    (ctrl),
      .i_wb_rdt  (wb_rdt),
      .o_addr    (o_addr),
      .o_imm     (imm),
      .o_csr_imm (csr_imm)
   );

   imm_collector u_collector (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_shift   (ctrl.cnt_en),   // One bit per count cycle.
      .i_csr_sel (csr_sel),
      .i_imm     (imm),
      .i_csr_imm (csr_imm),
      .i_fmt     (fmt),
      .i_finish  (finish),
      .o_result  (o_result),
      .o_valid   (o_result_valid)
   );

endmodule

/* bench/tb_imm_cases.svh */
`ifndef TB_IMM_CASES_SVH
`define TB_IMM_CASES_SVH

// Columns are name, instruction, format, rd, rs1, rs2, immediate, second strobe while busy.
// Immediates are worked out by hand from the field rules of each format.
task automatic build_case_table();
   // I-type, positive and negative immediates.
   add_case("addi_pos", 32'h12330293, imm_pkg::FMT_I, 5'd5, 5'd6, 5'd3, 32'h00000123, 1'b0);
   add_case("addi_neg", 32'hFFF10093, imm_pkg::FMT_I, 5'd1, 5'd2, 5'd31, 32'hFFFFFFFF, 1'b0);
   add_case("lw_min", 32'h8005A503, imm_pkg::FMT_I, 5'd10, 5'd11, 5'd0, 32'hFFFFF800, 1'b0);
   add_case("jalr_max", 32'h7FF280E7, imm_pkg::FMT_I, 5'd1, 5'd5, 5'd31, 32'h000007FF, 1'b0);
   add_case("csrrw", 32'h800110F3, imm_pkg::FMT_I, 5'd1, 5'd2, 5'd0, 32'hFFFFF800, 1'b0);

   // S-type splits the immediate around rs1 and rs2.
   add_case("sw_pos", 32'h2A742223, imm_pkg::FMT_S, 5'd4, 5'd8, 5'd7, 32'h000002A4, 1'b0);
   add_case("sb_neg", 32'hFFF10EA3, imm_pkg::FMT_S, 5'd29, 5'd2, 5'd31, 32'hFFFFFFFD, 1'b0);

   add_case("lui", 32'hABCDE1B7, imm_pkg::FMT_U, 5'd3, 5'd27, 5'd28, 32'hABCDE000, 1'b0);
   add_case("auipc", 32'h00012217, imm_pkg::FMT_U, 5'd4, 5'd2, 5'd0, 32'h00012000, 1'b0);

   // Bit 31 set, yet the CSR immediate stays zero-extended.
   add_case("csrrsi", 32'hC00FE4F3, imm_pkg::FMT_CSR, 5'd9, 5'd31, 5'd0, 32'h0000001F, 1'b0);
   add_case("csrrci", 32'hFFFAF673, imm_pkg::FMT_CSR, 5'd12, 5'd21, 5'd31, 32'h00000015, 1'b0);

   // Branch is accepted but yields no result, the next row must still work.
   add_case("beq", 32'h00208463, imm_pkg::FMT_NONE, 5'd8, 5'd1, 5'd2, 32'h00000000, 1'b0);
   add_case("addi_next", 32'hFFB00393, imm_pkg::FMT_I, 5'd7, 5'd0, 5'd27, 32'hFFFFFFFB, 1'b0);

   add_case("busy_drop", 32'h555A8A13, imm_pkg::FMT_I, 5'd20, 5'd21, 5'd21, 32'h00000555, 1'b1);
endtask

`endif

/* bench/tb_serial_imm_unit.sv */
`timescale 1ns/1ns
`include "imm_settings.svh"

module tb_serial_imm_unit;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 4;
   localparam int RANDOM_ROWS  = 8;
   localparam int WAIT_LIMIT   = 40;   // Cycles allowed per row.
   localparam int TAIL_CYCLES  = 2;
   localparam logic [31:0] LATE_INSTR = 32'hFFFFF0B7;   // Lui sent while busy.

   logic                 i_clk = 1'b0;
   logic                 i_rst;
   logic                 i_valid;
   logic [`IMM_XLEN-1:0] i_instr;
   logic                 o_busy;
   imm_pkg::reg_addr_t   o_addr;
   imm_pkg::imm_result_t o_result;
   logic                 o_result_valid;

   string              case_name[$];
   logic [31:0]        case_instr[$];
   imm_pkg::imm_fmt_e  case_fmt[$];
   imm_pkg::reg_addr_t case_addr[$];
   logic [31:0]        case_imm[$];
   logic               case_overlap[$];

   int   case_errors;
   int   pass_count;
   int   fail_count;
   logic table_ready = 1'b0;

   serial_imm_unit dut (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_valid        (i_valid),
      .i_instr        (i_instr),
      .o_busy         (o_busy),
      .o_addr         (o_addr),
      .o_result       (o_result),
      .o_result_valid (o_result_valid)
   );

   initial begin
      forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
   end

   task automatic add_case(input string name, input logic [31:0] instr,
                           input imm_pkg::imm_fmt_e fmt, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [31:0] imm, input logic overlap);
      imm_pkg::reg_addr_t addr;
      addr.rd  = rd;
      addr.rs1 = rs1;
      addr.rs2 = rs2;
      case_name.push_back(name);
      case_instr.push_back(instr);
      case_fmt.push_back(fmt);
      case_addr.push_back(addr);
      case_imm.push_back(imm);
      case_overlap.push_back(overlap);
   endtask

   `include "tb_imm_cases.svh"

   function automatic logic [31:0] lcg_step(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] rule_imm(input imm_pkg::imm_fmt_e fmt,
                                            input logic [31:0] instr);
      case (fmt)
         imm_pkg::FMT_I:   return {{20{instr[31]}}, instr[31:20]};
         imm_pkg::FMT_S:   return {{20{instr[31]}}, instr[31:25], instr[11:7]};
         imm_pkg::FMT_U:   return {instr[31:12], 12'h000};
         imm_pkg::FMT_CSR: return {27'd0, instr[19:15]};
         default:          return 32'd0;
      endcase
   endfunction

   task automatic append_random_rows();
      logic [31:0]       seed;
      logic [31:0]       instr;
      imm_pkg::imm_fmt_e fmt;
      int                n;
      seed = 32'd11;
      for (n = 0; n < RANDOM_ROWS; n++) begin
         seed  = lcg_step(seed);
         fmt   = (n % 2 == 0) ? imm_pkg::FMT_I : imm_pkg::FMT_S;
         instr = {seed[31:7], (fmt == imm_pkg::FMT_I) ? 7'b0010011 : 7'b0100011};
         add_case($sformatf("random_%0d", n), instr, fmt, instr[11:7], instr[19:15],
                  instr[24:20], rule_imm(fmt, instr), 1'b0);
      end
   endtask

   task automatic check_result(input string name, input imm_pkg::imm_result_t exp,
                               input imm_pkg::imm_result_t act);
      if (act !== exp) begin
         $display("error %s: result expected %h %s actual %h %s", name,
                  exp.value, exp.fmt.name(), act.value, act.fmt.name());
         case_errors++;
      end
   endtask

   task automatic compare_addr(input string name, input imm_pkg::reg_addr_t exp,
                               input imm_pkg::reg_addr_t act);
      if (act !== exp) begin
         $display("error %s: rd/rs1/rs2 expected %0d/%0d/%0d actual %0d/%0d/%0d", name,
                  exp.rd, exp.rs1, exp.rs2, act.rd, act.rs1, act.rs2);
         case_errors++;
      end
   endtask

   task automatic verify_latency(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("error %s: latency expected %0d actual %0d", name, exp, act);
         case_errors++;
      end
   endtask

   task automatic run_case(input int idx);
      imm_pkg::imm_result_t exp_result;
      int                   cycles;
      logic                 seen;
      exp_result.value = case_imm[idx];
      exp_result.fmt   = case_fmt[idx];
      case_errors      = 0;
      seen             = 1'b0;
      @(negedge i_clk);
      i_valid = 1'b1;
      i_instr = case_instr[idx];
      @(negedge i_clk);
      i_valid = 1'b0;
      cycles  = 1;   // First cycle after acceptance.
      if (!o_busy) begin
         $display("%s: o_busy stayed low after the strobe", case_name[idx]);
         case_errors++;
      end
      if (case_fmt[idx] != imm_pkg::FMT_NONE) begin
         compare_addr(case_name[idx], case_addr[idx], o_addr);
      end
      if (case_overlap[idx]) begin
         i_valid = 1'b1;
         i_instr = LATE_INSTR;
         @(negedge i_clk);
         i_valid = 1'b0;
         cycles++;
      end
      if (case_fmt[idx] == imm_pkg::FMT_NONE) begin
         while (o_busy && cycles < WAIT_LIMIT) begin
            @(negedge i_clk);
            cycles++;
            if (o_result_valid) begin
               seen = 1'b1;
            end
         end
         if (seen) begin
            $display("%s: a result pulse came for an instruction with no immediate",
                     case_name[idx]);
            case_errors++;
         end
         if (o_busy) begin
            $display("%s: o_busy never dropped", case_name[idx]);
            case_errors++;
         end
      end else begin
         while (!o_result_valid && cycles < WAIT_LIMIT) begin
            @(negedge i_clk);
            cycles++;
         end
         if (!o_result_valid) begin
            $display("%s: no result pulse within %0d cycles", case_name[idx], WAIT_LIMIT);
            case_errors++;
         end else begin
            verify_latency(case_name[idx], `IMM_CNT_LEN, cycles - 1);
            check_result(case_name[idx], exp_result, o_result);
            if (!o_busy) begin
               $display("%s: o_busy dropped before the result pulse", case_name[idx]);
               case_errors++;
            end
            repeat (TAIL_CYCLES) begin
               @(negedge i_clk);
               if (o_result_valid) begin
                  $display("%s: a second result pulse followed", case_name[idx]);
                  case_errors++;
               end
               if (o_busy) begin
                  $display("%s: o_busy still high after the result", case_name[idx]);
                  case_errors++;
               end
            end
         end
      end
      if (case_errors == 0) begin
         $display("%s: ok", case_name[idx]);
         pass_count++;
      end else begin
         $display("%s: failed with %0d errors", case_name[idx], case_errors);
         fail_count++;
      end
   endtask

   initial begin
      int idx;
      i_rst      = 1'b1;
      i_valid    = 1'b0;
      i_instr    = '0;
      pass_count = 0;
      fail_count = 0;
      build_case_table();
      append_random_rows();
      table_ready = 1'b1;
      repeat (RESET_CYCLES) @(negedge i_clk);
      i_rst = 1'b0;
      for (idx = 0; idx < case_name.size(); idx++) begin
         run_case(idx);
      end
      $display("%0d tests run, %0d passed, %0d failed", case_name.size(), pass_count,
               fail_count);
      if (fail_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      int limit;
      wait (table_ready);
      limit = case_name.size() * WAIT_LIMIT + 20;   // Rows plus reset margin.
      repeat (limit) @(posedge i_clk);
      $display("watchdog: the run did not finish within %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
   end

endmodule

/* serial_imm_unit.f */
+incdir+logic
+incdir+bench
logic/imm_pkg.sv
logic/imm_sequencer.sv
logic/serial_immdec.sv
logic/imm_collector.sv
logic/serial_imm_unit.sv
bench/tb_serial_imm_unit.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_serial_imm_unit \
   -f serial_imm_unit.f \
   && ./obj_dir/Vtb_serial_imm_unit | tee /dev/stderr | grep -qx "TEST PASSED" \
   && echo "run.sh: simulation passed" \
   || { echo "run.sh: simulation failed"; exit 1; }
